// ==== isa_pkg.sv ====
// Instruction-set definitions shared by decode and execute, imported where fields or opcodes are used
package isa_pkg;

  // Datapath and instruction word width
  localparam int word_width = 32;

  // Register file geometry
  localparam int reg_index_width = 4;
  localparam int num_regs = 16;

  // Immediate field, sign-extended to a word
  localparam int imm_width = 16;

  // Bit positions of the instruction fields
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 28;
  localparam int dst_msb = 27;
  localparam int dst_lsb = 24;
  localparam int src1_msb = 23;
  localparam int src1_lsb = 20;
  localparam int src2_msb = 19;
  localparam int src2_lsb = 16;
  localparam int imm_msb = 15;
  localparam int imm_lsb = 0;

  // Major opcodes, unlisted encodings behave as nop
  typedef enum logic [3:0] {
    op_nop   = 4'd0,
    op_add   = 4'd1,
    op_sub   = 4'd2,
    op_and   = 4'd3,
    op_or    = 4'd4,
    op_addi  = 4'd5,
    op_load  = 4'd6,
    op_store = 4'd7,
    op_beq   = 4'd8
  } opcode_e;

  // ALU functions
  typedef enum logic [1:0] {
    alu_add = 2'd0,
    alu_sub = 2'd1,
    alu_and = 2'd2,
    alu_or  = 2'd3
  } alu_op_e;

endpackage

// ==== pipe_pkg.sv ====
// Pipeline-level definitions, the control bundle and data memory size, imported by pipeline stages
package pipe_pkg;

  import isa_pkg::*;

  // Data memory depth, addressed by the low ALU result bits
  localparam int dmem_words = 64;
  localparam int dmem_index_width = 6;

  // Control bundle produced by decode and carried to execute
  typedef struct packed {
    // Slot holds an instruction, low for a bubble
    logic    valid;
    // Result goes back to the register file
    logic    reg_write;
    // Result comes from data memory
    logic    mem_read;
    // op_b is written to data memory
    logic    mem_write;
    // Branch compare and target report
    logic    branch;
    // Second ALU operand is the immediate
    logic    alu_src_imm;
    // ALU function
    alu_op_e alu_op;
  } ctrl_t;

endpackage

// ==== id_ex_if.sv ====
// Decode-to-execute bundle, driven by the decode register and read by execute and hazard logic
`timescale 1ns/1ps

interface id_ex_if import isa_pkg::*, pipe_pkg::*; ();

  // Control bundle, valid low marks a bubble
  ctrl_t                      ctrl;
  // Instruction address, base of the branch target
  logic [word_width-1:0]      pc;
  // Register operands read at decode
  logic [word_width-1:0]      op_a;
  logic [word_width-1:0]      op_b;
  // Sign-extended immediate
  logic [word_width-1:0]      imm;
  // Destination register index
  logic [reg_index_width-1:0] dst;
  // Raw word, execute takes the branch kind from it
  logic [word_width-1:0]      instr;

  // Decode register side
  modport stage_out (output ctrl, pc, op_a, op_b, imm, dst, instr);
  // Execute and hazard side
  modport stage_in (input ctrl, pc, op_a, op_b, imm, dst, instr);

endinterface

// ==== control_unit.sv ====
// Combinational instruction decoder feeding the register file, hazard check and decode register
`timescale 1ns/1ps

module control_unit import isa_pkg::*, pipe_pkg::*; (
  input  logic [word_width-1:0]      instr,
  output ctrl_t                      ctrl,
  output logic [reg_index_width-1:0] dst,
  output logic [reg_index_width-1:0] src1,
  output logic [reg_index_width-1:0] src2,
  output logic [word_width-1:0]      imm
);

  opcode_e opcode;

  assign opcode = opcode_e'(instr[opcode_msb:opcode_lsb]);

  // Sign extension of the low field
  assign imm = {{(word_width - imm_width){instr[imm_msb]}}, instr[imm_msb:imm_lsb]};

  always_comb
  begin
    // Every presented word is an instruction; effects come from the flags below
    ctrl = '0;
    ctrl.valid = 1'b1;
    ctrl.alu_op = alu_add;
    dst = instr[dst_msb:dst_lsb];
    src1 = instr[src1_msb:src1_lsb];
    src2 = instr[src2_msb:src2_lsb];
    case (opcode)
      op_add:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = alu_add;
      end
      op_sub:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = alu_sub;
      end
      op_and:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = alu_and;
      end
      op_or:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = alu_or;
      end
      op_addi:
      begin
        // Immediate replaces src2, which then reads r0
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        src2 = '0;
      end
      op_load:
      begin
        // Address is src1 plus immediate
        ctrl.reg_write = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        src2 = '0;
      end
      op_store:
      begin
        // src2 supplies the store data, no register result
        ctrl.mem_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        dst = '0;
      end
      op_beq:
      begin
        // Equality via subtract, result unused otherwise
        ctrl.branch = 1'b1;
        ctrl.alu_op = alu_sub;
        dst = '0;
      end
      default:
      begin
        // Nop reads and writes only r0 so it never stalls
        dst = '0;
        src1 = '0;
        src2 = '0;
      end
    endcase
  end

endmodule

// ==== register_file.sv ====
// Sixteen-entry register file with write-through reads, read at decode and written from write-back
`timescale 1ns/1ps

module register_file import isa_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [reg_index_width-1:0] rd_addr_a,
  input  logic [reg_index_width-1:0] rd_addr_b,
  output logic [word_width-1:0]      rd_data_a,
  output logic [word_width-1:0]      rd_data_b,
  input  logic                       wr_en,
  input  logic [reg_index_width-1:0] wr_addr,
  input  logic [word_width-1:0]      wr_data
);

  logic [word_width-1:0] regs [num_regs];

  // r0 is never written
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < num_regs; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en && (wr_addr != '0))
    begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Same-cycle write returned to the reader, covers the conflict two stages apart
  always_comb
  begin
    if (rd_addr_a == '0)
      rd_data_a = '0;
    else if (wr_en && (wr_addr == rd_addr_a))
      rd_data_a = wr_data;
    else
      rd_data_a = regs[rd_addr_a];

    if (rd_addr_b == '0)
      rd_data_b = '0;
    else if (wr_en && (wr_addr == rd_addr_b))
      rd_data_b = wr_data;
    else
      rd_data_b = regs[rd_addr_b];
  end

endmodule

// ==== hazard_unit.sv ====
// Read-after-write detector between decode and the decode register, drives the one-cycle stall
`timescale 1ns/1ps

module hazard_unit import isa_pkg::*; (
  input  logic [reg_index_width-1:0] src1,
  input  logic [reg_index_width-1:0] src2,
  input  logic                       dec_valid,
  id_ex_if.stage_in                  ex,
  output logic                       stall
);

  logic writer;
  logic hit_a;
  logic hit_b;

  // Instruction one stage ahead that will write a register
  assign writer = ex.ctrl.valid && ex.ctrl.reg_write;

  // r0 reads never conflict
  assign hit_a = (src1 != '0) && (src1 == ex.dst);
  assign hit_b = (src2 != '0) && (src2 == ex.dst);

  // Bubble follows, so the stall clears on the next cycle
  assign stall = dec_valid && writer && (hit_a || hit_b);

endmodule

// ==== decode_registers.sv ====
// Decode-to-execute pipeline register, loads a bubble on stall or when no word is presented
`timescale 1ns/1ps

module decode_registers import isa_pkg::*, pipe_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       stall,
  input  logic                       in_valid,
  input  logic [word_width-1:0]      instr,
  input  logic [word_width-1:0]      pc,
  input  ctrl_t                      ctrl,
  input  logic [word_width-1:0]      op_a,
  input  logic [word_width-1:0]      op_b,
  input  logic [word_width-1:0]      imm,
  input  logic [reg_index_width-1:0] dst,
  id_ex_if.stage_out                 out
);

  logic load;

  // Word accepted on this edge
  assign load = in_valid && !stall;

  // Control bundle, cleared to a bubble unless a word is accepted
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out.ctrl <= '0;
    end
    else if (load)
    begin
      out.ctrl <= ctrl;
    end
    else
    begin
      out.ctrl <= '0;
    end
  end

  // Payload captured every edge, meaningful only with ctrl.valid
  always_ff @(posedge clk)
  begin
    out.instr <= instr;
    out.pc <= pc;
    out.op_a <= op_a;
    out.op_b <= op_b;
    out.imm <= imm;
    out.dst <= dst;
  end

endmodule

// ==== execute_stage.sv ====
// Execute stage with ALU, branch compare, data memory and the write-back register
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  id_ex_if.stage_in                  in,
  output logic                       wb_valid,
  output logic [reg_index_width-1:0] wb_reg,
  output logic [word_width-1:0]      wb_data,
  output logic                       br_valid,
  output logic                       br_taken,
  output logic [word_width-1:0]      br_target,
  output logic                       wr_en,
  output logic [reg_index_width-1:0] wr_addr,
  output logic [word_width-1:0]      wr_data
);

  opcode_e                     opcode;
  logic [word_width-1:0]       alu_b;
  logic [word_width-1:0]       alu_result;
  logic [dmem_index_width-1:0] mem_addr;
  logic [word_width-1:0]       result;
  logic                        cond_met;
  logic [word_width-1:0]       dmem [dmem_words];

  // Write-back register
  logic                        res_valid;
  logic                        res_write;
  logic                        res_branch;
  logic                        res_taken;
  logic [reg_index_width-1:0]  res_dst;
  logic [word_width-1:0]       res_data;
  logic [word_width-1:0]       res_target;

  assign opcode = opcode_e'(in.instr[opcode_msb:opcode_lsb]);

  // Operand select and ALU
  assign alu_b = in.ctrl.alu_src_imm ? in.imm : in.op_b;

  always_comb
  begin
    case (in.ctrl.alu_op)
      alu_add: alu_result = in.op_a + alu_b;
      alu_sub: alu_result = in.op_a - alu_b;
      alu_and: alu_result = in.op_a & alu_b;
      default: alu_result = in.op_a | alu_b;
    endcase
  end

  // Word address wraps modulo the memory depth
  assign mem_addr = alu_result[dmem_index_width-1:0];

  // Branch kind comes from the opcode, beq is the only compare so far
  always_comb
  begin
    cond_met = 1'b0;
    if (in.ctrl.branch)
    begin
      case (opcode)
        op_beq: cond_met = (alu_result == '0);
        default: cond_met = 1'b0;
      endcase
    end
  end

  // Load data or ALU value
  assign result = in.ctrl.mem_read ? dmem[mem_addr] : alu_result;

  // Data memory, store visible to a load one cycle behind
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < dmem_words; i++)
      begin
        dmem[i] <= '0;
      end
    end
    else if (in.ctrl.valid && in.ctrl.mem_write)
    begin
      dmem[mem_addr] <= in.op_b;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      res_valid <= 1'b0;
    else
      res_valid <= in.ctrl.valid;
  end

  // Payload side, qualified by res_valid
  always_ff @(posedge clk)
  begin
    res_write <= in.ctrl.reg_write && (in.dst != '0);  // r0 writes are dropped here
    res_branch <= in.ctrl.branch;
    res_taken <= cond_met;
    res_dst <= in.dst;
    res_data <= result;
    res_target <= in.pc + in.imm;
  end

  // Result report and register file write port
  assign wb_valid = res_valid && res_write;
  assign wb_reg = res_dst;
  assign wb_data = res_data;
  assign wr_en = res_valid && res_write;
  assign wr_addr = res_dst;
  assign wr_data = res_data;

  // Branch report
  assign br_valid = res_valid && res_branch;
  assign br_taken = res_taken;
  assign br_target = res_target;

endmodule

// ==== core_top.sv ====
// Decode and execute slice top level, plain ports toward the fetch source and result consumers
`timescale 1ns/1ps

module core_top import isa_pkg::*, pipe_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  input  logic [word_width-1:0]      in_instr,
  input  logic [word_width-1:0]      in_pc,
  output logic                       in_ready,
  output logic                       wb_valid,
  output logic [reg_index_width-1:0] wb_reg,
  output logic [word_width-1:0]      wb_data,
  output logic                       br_valid,
  output logic                       br_taken,
  output logic [word_width-1:0]      br_target
);

  // Decode stage signals
  ctrl_t                      dec_ctrl;
  logic [reg_index_width-1:0] dec_dst;
  logic [reg_index_width-1:0] dec_src1;
  logic [reg_index_width-1:0] dec_src2;
  logic [word_width-1:0]      dec_imm;
  logic [word_width-1:0]      rd_data_a;
  logic [word_width-1:0]      rd_data_b;
  logic                       stall;

  // Write-back to register file
  logic                       wr_en;
  logic [reg_index_width-1:0] wr_addr;
  logic [word_width-1:0]      wr_data;

  id_ex_if ex_bus ();

  // Word accepted whenever no conflict is pending
  assign in_ready = !stall;

  control_unit control_unit_i (
    .instr (in_instr),
    .ctrl  (dec_ctrl),
    .dst   (dec_dst),
    .src1  (dec_src1),
    .src2  (dec_src2),
    .imm   (dec_imm)
  );

  register_file register_file_i (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_a (dec_src1),
    .rd_addr_b (dec_src2),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  hazard_unit hazard_unit_i (
    .src1      (dec_src1),
    .src2      (dec_src2),
    .dec_valid (in_valid),
    .ex        (ex_bus.stage_in),
    .stall     (stall)
  );

  decode_registers decode_registers_i (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .in_valid (in_valid),
    .instr    (in_instr),
    .pc       (in_pc),
    .ctrl     (dec_ctrl),
    .op_a     (rd_data_a),
    .op_b     (rd_data_b),
    .imm      (dec_imm),
    .dst      (dec_dst),
    .out      (ex_bus.stage_out)
  );

  execute_stage execute_stage_i (
    .clk       (clk),
    .rst       (rst),
    .in        (ex_bus.stage_in),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .br_valid  (br_valid),
    .br_taken  (br_taken),
    .br_target (br_target),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

endmodule

// ==== tb_clock.sv ====
// Testbench clock and reset source, 10 ns period with reset held for the first two rising edges
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  // Reset released on the second rising edge
  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

  // 100 MHz
  always #5 clk = ~clk;

endmodule

// ==== core_asserts.sv ====
// Concurrent checks on stall length, output exclusivity and pipeline latency, bound into core_top
`timescale 1ns/1ps

module core_asserts (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic in_ready,
  input logic wb_valid,
  input logic br_valid,
  input logic res_valid
);

  // Bubble behind a stalled word clears the conflict on the next cycle
  stall_one_cycle: assert property (@(posedge clk) disable iff (rst) !in_ready |=> in_ready)
    else $error("in_ready stayed low for two cycles in a row");

  // One instruction per slot, so never a write and a branch at once
  single_report: assert property (@(posedge clk) disable iff (rst) !(wb_valid && br_valid))
    else $error("write-back and branch report valid in the same cycle");

  // Accepted at edge N, in the write-back register from N+1
  accept_latency: assert property (@(posedge clk) disable iff (rst)
    $past(in_valid && in_ready, 2) |-> res_valid)
    else $error("accepted word missing from the write-back register two edges later");

endmodule

// Attach to every core_top, write-back valid taken from inside execute
bind core_top core_asserts asserts_i (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .wb_valid  (wb_valid),
  .br_valid  (br_valid),
  .res_valid (execute_stage_i.res_valid)
);

// ==== core_tb.sv ====
// Self-checking testbench, feeds random programs with gaps and checks results against an ISA model
`timescale 1ns/1ps

module core_tb import isa_pkg::*, pipe_pkg::*; ();

  // Directed prologue followed by random words
  localparam int num_directed = 10;
  localparam int num_random = 300;
  localparam int num_instr = num_directed + num_random;
  // At most one stall or gap per word, plus reset and drain
  localparam int cycle_limit = 2 * num_instr + 50;

  logic                       clk;
  logic                       rst;
  logic                       in_valid = 1'b0;
  logic [word_width-1:0]      in_instr = '0;
  logic [word_width-1:0]      in_pc = '0;
  logic                       in_ready;
  logic                       wb_valid;
  logic [reg_index_width-1:0] wb_reg;
  logic [word_width-1:0]      wb_data;
  logic                       br_valid;
  logic                       br_taken;
  logic [word_width-1:0]      br_target;

  // Program, gap pattern and filler shown while in_valid is low
  logic [word_width-1:0] prog [num_instr];
  bit                    gap [num_instr];
  logic [word_width-1:0] junk [num_instr + 1];
  int                    seed = 32'hb5e3_c5cc;
  int                    next_idx = 0;

  // Acceptance seen at the falling edge, used by the driver at the next rising edge
  logic will_accept = 1'b0;
  logic fed_all = 1'b0;
  int   accepted_count = 0;
  int   cycles = 0;
  int   value_errors = 0;
  int   event_errors = 0;

  // Register written by the last accepted word, r0 when it writes none
  logic [reg_index_width-1:0] prev_dst = '0;

  // Reference model state
  logic [word_width-1:0] model_regs [num_regs];
  logic [word_width-1:0] model_mem [dmem_words];

  // Expected events in program order, kind 1 is a branch report
  bit                         exp_kind [$];
  logic [reg_index_width-1:0] exp_reg [$];
  logic [word_width-1:0]      exp_data [$];
  logic                       exp_taken [$];
  logic [word_width-1:0]      exp_target [$];

  tb_clock clock_i (
    .clk (clk),
    .rst (rst)
  );

  core_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .in_pc     (in_pc),
    .in_ready  (in_ready),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .br_valid  (br_valid),
    .br_taken  (br_taken),
    .br_target (br_target)
  );

  function automatic logic [word_width-1:0] encode(
    input opcode_e                    op,
    input logic [reg_index_width-1:0] d,
    input logic [reg_index_width-1:0] s1,
    input logic [reg_index_width-1:0] s2,
    input logic [imm_width-1:0]       imm
  );
    return {op, d, s1, s2, imm};
  endfunction

  // Non-negative value below limit
  function automatic int rand_below(input int limit);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % limit;
  endfunction

  // Whether a word reads nonzero register r as a source, by its opcode
  function automatic bit reads_reg(
    input logic [word_width-1:0]      instr,
    input logic [reg_index_width-1:0] r
  );
    opcode_e op;
    bit      hit1;
    bit      hit2;
    bit      res;
    op = opcode_e'(instr[opcode_msb:opcode_lsb]);
    hit1 = (r != '0) && (instr[src1_msb:src1_lsb] == r);
    hit2 = (r != '0) && (instr[src2_msb:src2_lsb] == r);
    case (op)
      op_add, op_sub, op_and, op_or, op_store, op_beq: res = hit1 || hit2;
      op_addi, op_load: res = hit1;
      default: res = 1'b0;
    endcase
    return res;
  endfunction

  task automatic build_program();
    logic [3:0]                 opc;
    logic [imm_width-1:0]       imm;
    // Store then load of one address, dependent pairs, r0 write, two-apart reuse
    prog[0] = encode(op_addi, 4'd1, 4'd0, 4'd0, 16'd5);
    prog[1] = encode(op_addi, 4'd2, 4'd0, 4'd0, 16'hfff9);
    prog[2] = encode(op_store, 4'd0, 4'd1, 4'd2, 16'd3);
    prog[3] = encode(op_load, 4'd3, 4'd1, 4'd0, 16'd3);
    prog[4] = encode(op_beq, 4'd0, 4'd3, 4'd2, 16'd16);
    prog[5] = encode(op_beq, 4'd0, 4'd1, 4'd2, 16'hfff8);
    prog[6] = encode(op_add, 4'd0, 4'd1, 4'd2, 16'd0);
    prog[7] = encode(op_sub, 4'd4, 4'd1, 4'd2, 16'd0);
    prog[8] = encode(op_and, 4'd5, 4'd4, 4'd1, 16'd0);
    prog[9] = encode(op_or, 4'd6, 4'd4, 4'd1, 16'd0);
    // Registers r0 to r3 only, so conflicts are frequent; code 9 is an unused opcode
    for (int i = num_directed; i < num_instr; i++)
    begin
      opc = 4'(rand_below(10));
      if (opc == 4'(op_load) || opc == 4'(op_store))
        imm = imm_width'(rand_below(8) - 4);
      else
        imm = imm_width'($random(seed));
      prog[i] = encode(opcode_e'(opc), reg_index_width'(rand_below(4)),
                       reg_index_width'(rand_below(4)), reg_index_width'(rand_below(4)), imm);
    end
    for (int i = 0; i < num_instr; i++)
    begin
      gap[i] = (rand_below(4) == 0);
    end
    for (int i = 0; i <= num_instr; i++)
    begin
      junk[i] = $random(seed);
    end
  endtask

  // In-order execution of one word, queues what the DUT must report
  task automatic run_model(input logic [word_width-1:0] instr, input logic [word_width-1:0] pc);
    opcode_e                     op;
    logic [reg_index_width-1:0]  d;
    logic [word_width-1:0]       a;
    logic [word_width-1:0]       b;
    logic [word_width-1:0]       imm;
    logic [word_width-1:0]       sum;
    logic [word_width-1:0]       res;
    logic [dmem_index_width-1:0] maddr;
    logic                        writes;
    op = opcode_e'(instr[opcode_msb:opcode_lsb]);
    d = instr[dst_msb:dst_lsb];
    a = model_regs[instr[src1_msb:src1_lsb]];
    b = model_regs[instr[src2_msb:src2_lsb]];
    imm = 32'($signed(instr[imm_msb:imm_lsb]));
    sum = a + imm;
    maddr = sum[dmem_index_width-1:0];
    writes = 1'b1;
    res = '0;
    case (op)
      op_add: res = a + b;
      op_sub: res = a - b;
      op_and: res = a & b;
      op_or: res = a | b;
      op_addi: res = sum;
      op_load: res = model_mem[maddr];
      op_store:
      begin
        writes = 1'b0;
        model_mem[maddr] = b;
      end
      op_beq:
      begin
        writes = 1'b0;
        exp_kind.push_back(1'b1);
        exp_taken.push_back(a == b);
        exp_target.push_back(pc + imm);
      end
      default: writes = 1'b0;
    endcase
    // r0 stays zero and is never reported
    if (writes && d != 4'd0)
    begin
      model_regs[d] = res;
      exp_kind.push_back(1'b0);
      exp_reg.push_back(d);
      exp_data.push_back(res);
    end
    prev_dst = writes ? d : '0;
  endtask

  task automatic check_wb(
    input logic [reg_index_width-1:0] got_reg,
    input logic [reg_index_width-1:0] want_reg,
    input logic [word_width-1:0]      got_data,
    input logic [word_width-1:0]      want_data
  );
    if (got_reg !== want_reg || got_data !== want_data)
    begin
      value_errors++;
      $display("FAILED at %0t: write r%0d = %h, expected r%0d = %h",
               $time, got_reg, got_data, want_reg, want_data);
    end
  endtask

  task automatic check_br(
    input logic                  got_taken,
    input logic                  want_taken,
    input logic [word_width-1:0] got_target,
    input logic [word_width-1:0] want_target
  );
    if (got_taken !== want_taken || got_target !== want_target)
    begin
      value_errors++;
      $display("FAILED at %0t: branch taken %b target %h, expected taken %b target %h",
               $time, got_taken, got_target, want_taken, want_target);
    end
  endtask

  task automatic check_ready(input logic got_ready, input logic want_ready);
    if (got_ready !== want_ready)
    begin
      value_errors++;
      $display("FAILED at %0t: in_ready %b, expected %b", $time, got_ready, want_ready);
    end
  endtask

  // Pops the oldest expected event and compares it with the output seen
  task automatic take_event(input bit is_branch);
    bit                         kind;
    logic [reg_index_width-1:0] e_reg;
    logic [word_width-1:0]      e_data;
    logic                       e_taken;
    logic [word_width-1:0]      e_target;
    if (exp_kind.size() == 0)
    begin
      event_errors++;
      $display("output event at %0t while no result was pending", $time);
    end
    else
    begin
      kind = exp_kind.pop_front();
      if (kind)
      begin
        e_taken = exp_taken.pop_front();
        e_target = exp_target.pop_front();
      end
      else
      begin
        e_reg = exp_reg.pop_front();
        e_data = exp_data.pop_front();
      end
      if (kind != is_branch)
      begin
        event_errors++;
        $display("results out of program order at %0t, a %s was due first",
                 $time, kind ? "branch report" : "register write");
      end
      else if (kind)
        check_br(br_taken, e_taken, br_target, e_target);
      else
        check_wb(wb_reg, e_reg, wb_data, e_data);
    end
  endtask

  task automatic print_counts(input int missing);
    $display("errors: %0d wrong values, %0d event errors, %0d results missing",
             value_errors, event_errors, missing);
  endtask

  // Word held until accepted; one idle cycle may follow an accepted word
  always @(posedge clk)
  begin
    if (rst)
    begin
      in_valid <= 1'b0;
    end
    else if (!in_valid || will_accept)
    begin
      if (next_idx >= num_instr || (in_valid && gap[next_idx]))
      begin
        // Filler content must be ignored
        in_valid <= 1'b0;
        in_instr <= junk[next_idx];
        in_pc <= ~junk[next_idx];
      end
      else
      begin
        in_valid <= 1'b1;
        in_instr <= prog[next_idx];
        in_pc <= 32'(next_idx * 4);
        next_idx = next_idx + 1;
      end
    end
  end

  // Outputs and the handshake are settled mid-cycle
  always @(negedge clk)
  begin
    if (rst)
    begin
      will_accept = 1'b0;
      fed_all = 1'b0;
      accepted_count = 0;
      prev_dst = '0;
      for (int i = 0; i < num_regs; i++)
      begin
        model_regs[i] = '0;
      end
      for (int i = 0; i < dmem_words; i++)
      begin
        model_mem[i] = '0;
      end
    end
    else
    begin
      // Results belong to older words than the one accepted next
      if (wb_valid)
        take_event(1'b0);
      if (br_valid)
        take_event(1'b1);
      // Word accepted at the last edge sits in the decode register and may block this one
      check_ready(in_ready, !(in_valid && will_accept && reads_reg(in_instr, prev_dst)));
      will_accept = in_valid && in_ready;
      if (will_accept)
      begin
        run_model(in_instr, in_pc);
        accepted_count = accepted_count + 1;
        fed_all = (accepted_count == num_instr);
      end
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("timeout after %0d cycles, the program never completed", cycle_limit);
      print_counts(exp_kind.size());
      $display("TB FAILED");
      $finish;
    end
  end

  initial
  begin
    int missing;
    build_program();
    wait (fed_all);
    // Last word reports in the cycle after its second edge, then idle edges catch strays
    repeat (4) @(posedge clk);
    missing = exp_kind.size();
    if (missing != 0)
      $display("%0d expected results never appeared at the outputs", missing);
    print_counts(missing);
    if (value_errors == 0 && event_errors == 0 && missing == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== core_top.f ====
isa_pkg.sv
pipe_pkg.sv
id_ex_if.sv
control_unit.sv
register_file.sv
hazard_unit.sv
decode_registers.sv
execute_stage.sv
core_top.sv
tb_clock.sv
core_asserts.sv
core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module core_tb -f core_top.f -o core_sim

./obj_dir/core_sim 2>&1 | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
